// File: hdl/frame_dispatcher.sv
// frame dispatcher that hunts for the sync byte, gathers the payload and commits one command
`timescale 1ns/1ps

module frame_dispatcher #(
    parameter logic [7:0] SYNC_BYTE = 8'h55
) (
    input  logic          clk,
    input  logic          reset,
    input  logic [7:0]    rx_byte,
    input  logic          rx_valid,
    input  logic          frame_abort,
    led_cmd_if.dispatcher cmd
);
    import frame_pkg::*;
    import led_pkg::*;

    frame_state_e state;
    logic [2:0]   field_idx;
    logic         commit;

    // fields of the frame in progress, only copied out once the frame is whole
    channel_t     intensity_hold;
    logic [7:0]   color_idx_hold;
    rgbw_t        color_hold;

    // the mode byte is the last field and is taken straight from the receiver
    assign commit = rx_valid && !frame_abort && (state == ST_COLLECT) &&
                    (field_idx == FIELD_MODE);

    always_ff @(posedge clk) begin
        if (!reset) begin
            state     <= ST_HUNT;
            field_idx <= '0;
        end else if (frame_abort) begin
            // a cs_n rise ends the frame wherever it stood
            state     <= ST_HUNT;
            field_idx <= '0;
        end else if (rx_valid) begin
            case (state)
                ST_HUNT: begin
                    if (rx_byte == SYNC_BYTE) begin
                        state     <= ST_COLLECT;
                        field_idx <= '0;
                    end
                end
                ST_COLLECT: begin
                    if (commit) begin
                        state     <= ST_HUNT;
                        field_idx <= '0;
                    end else begin
                        field_idx <= field_idx + 3'd1;
                    end
                end
                default: begin
                    state     <= ST_HUNT;
                    field_idx <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rx_valid && state == ST_COLLECT) begin
            case (field_idx)
                FIELD_INTENSITY: intensity_hold   <= rx_byte;
                FIELD_COLOR_IDX: color_idx_hold   <= rx_byte;
                FIELD_RED:       color_hold.red   <= rx_byte;
                FIELD_GREEN:     color_hold.green <= rx_byte;
                FIELD_BLUE:      color_hold.blue  <= rx_byte;
                FIELD_WHITE:     color_hold.white <= rx_byte;
                default: begin
                end
            endcase
        end
    end

    // all fields change together so the generator never sees half a frame
    always_ff @(posedge clk) begin
        if (!reset) begin
            cmd.intensity <= '0;
            cmd.color_idx <= '0;
            cmd.color     <= '0;
            cmd.mode      <= MODE_OFF;
            cmd.update    <= 1'b0;
        end else begin
            cmd.update <= commit;
            if (commit) begin
                cmd.intensity <= intensity_hold;
                cmd.color_idx <= color_idx_hold;
                cmd.color     <= color_hold;
                cmd.mode      <= mode_e'(rx_byte);
            end
        end
    end

    a_field_idx_range : assert property (
        @(posedge clk) disable iff (!reset) field_idx < 3'(FRAME_FIELDS)
    ) else $error("field index ran past the last payload byte");

endmodule

// File: hdl/frame_pkg.sv
// SPI frame protocol: dispatcher states, mode opcodes and the frame field layout
package frame_pkg;

    // the dispatcher either hunts for the sync byte or collects payload fields
    typedef enum logic [0:0] {
        ST_HUNT    = 1'b0,
        ST_COLLECT = 1'b1
    } frame_state_e;

    // mode byte of a frame, any value not listed here behaves like MODE_OFF
    typedef enum logic [7:0] {
        MODE_OFF     = 8'd0,
        MODE_DIRECT  = 8'd1,
        MODE_PALETTE = 8'd2
    } mode_e;

    // payload bytes that follow the sync byte
    localparam int FRAME_FIELDS = 7;

    // position of each payload byte within the frame, counted after the sync byte
    localparam logic [2:0] FIELD_INTENSITY = 3'd0;
    localparam logic [2:0] FIELD_COLOR_IDX = 3'd1;
    localparam logic [2:0] FIELD_RED       = 3'd2;
    localparam logic [2:0] FIELD_GREEN     = 3'd3;
    localparam logic [2:0] FIELD_BLUE      = 3'd4;
    localparam logic [2:0] FIELD_WHITE     = 3'd5;
    localparam logic [2:0] FIELD_MODE      = 3'd6;

endpackage

// File: hdl/led_cmd_if.sv
// LED command bundle passed from the frame dispatcher to the color generator
`timescale 1ns/1ps

interface led_cmd_if;
    import frame_pkg::*;
    import led_pkg::*;

    channel_t   intensity;
    logic [7:0] color_idx;
    rgbw_t      color;
    mode_e      mode;
    // single-cycle strobe, the fields hold their values until the next strobe
    logic       update;

    modport dispatcher (
        output intensity,
        output color_idx,
        output color,
        output mode,
        output update
    );

    modport generator (
        input intensity,
        input color_idx,
        input color,
        input mode,
        input update
    );

endinterface

// File: hdl/led_ctrl_top.sv
// LED controller top level joining the SPI receiver, frame dispatcher and color generator
`timescale 1ns/1ps

module led_ctrl_top #(
    parameter logic [7:0] SYNC_BYTE = 8'h55,
    parameter int         PWM_BITS  = 8
) (
    input  logic clk,
    input  logic reset,
    input  logic sclk,
    input  logic cs_n,
    input  logic mosi,
    output logic pwm_red,
    output logic pwm_green,
    output logic pwm_blue,
    output logic pwm_white
);

    logic [7:0] rx_byte;
    logic       rx_valid;
    logic       frame_abort;

    led_cmd_if u_cmd_if ();

    spi_byte_rx u_spi_byte_rx (
        .clk         (clk),
        .reset       (reset),
        .sclk        (sclk),
        .cs_n        (cs_n),
        .mosi        (mosi),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .frame_abort (frame_abort)
    );

    frame_dispatcher #(
        .SYNC_BYTE (SYNC_BYTE)
    ) u_frame_dispatcher (
        .clk         (clk),
        .reset       (reset),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .frame_abort (frame_abort),
        .cmd         (u_cmd_if.dispatcher)
    );

    pwm_color_gen #(
        .PWM_BITS (PWM_BITS)
    ) u_pwm_color_gen (
        .clk       (clk),
        .reset     (reset),
        .cmd       (u_cmd_if.generator),
        .pwm_red   (pwm_red),
        .pwm_green (pwm_green),
        .pwm_blue  (pwm_blue),
        .pwm_white (pwm_white)
    );

endmodule

// File: hdl/led_pkg.sv
// LED channel types, the fixed color palette and the PWM arithmetic types
package led_pkg;

    // one 8-bit channel level, also used for the intensity byte
    typedef logic [7:0] channel_t;

    typedef struct packed {
        channel_t red;
        channel_t green;
        channel_t blue;
        channel_t white;
    } rgbw_t;

    // full product of a channel level and the intensity before it is cut to a duty
    typedef logic [15:0] product_t;

    // palette lookups use only the low bits of the color index byte
    typedef logic [2:0] palette_idx_t;

    localparam int NUM_COLORS = 8;

    localparam rgbw_t PALETTE [NUM_COLORS] = '{
        '{red: 8'hff, green: 8'h00, blue: 8'h00, white: 8'h00},
        '{red: 8'h00, green: 8'hff, blue: 8'h00, white: 8'h00},
        '{red: 8'h00, green: 8'h00, blue: 8'hff, white: 8'h00},
        '{red: 8'h00, green: 8'h00, blue: 8'h00, white: 8'hff},
        // amber with a little white to soften it
        '{red: 8'hff, green: 8'h80, blue: 8'h00, white: 8'h10},
        '{red: 8'h00, green: 8'hc0, blue: 8'hc0, white: 8'h00},
        '{red: 8'hc0, green: 8'h00, blue: 8'ha0, white: 8'h00},
        // warm white mixes all four channels
        '{red: 8'hff, green: 8'ha0, blue: 8'h50, white: 8'h80}
    };

endpackage

// File: hdl/pwm_color_gen.sv
// color generator that picks the color source, scales it by intensity and drives four PWM outputs
`timescale 1ns/1ps

module pwm_color_gen #(
    parameter int PWM_BITS = 8
) (
    input  logic         clk,
    input  logic         reset,
    led_cmd_if.generator cmd,
    output logic         pwm_red,
    output logic         pwm_green,
    output logic         pwm_blue,
    output logic         pwm_white
);
    import frame_pkg::*;
    import led_pkg::*;

    localparam int NUM_CH = 4;
    // the counter stops one short of all ones, so full scale is a 2^PWM_BITS - 1 period
    localparam logic [PWM_BITS-1:0] CNT_LAST = {{(PWM_BITS-1){1'b1}}, 1'b0};

    mode_e               lat_mode;
    channel_t            lat_intensity;
    palette_idx_t        lat_idx;
    rgbw_t               lat_color;
    rgbw_t               src_color;
    channel_t            src_ch [NUM_CH];
    logic [PWM_BITS-1:0] duty_next [NUM_CH];
    logic [PWM_BITS-1:0] duty [NUM_CH];
    logic [PWM_BITS-1:0] pwm_cnt;
    logic                cnt_wrap;
    logic                off_active;
    logic [NUM_CH-1:0]   pwm_out;

    // keep the upper PWM_BITS bits of level times intensity
    function automatic logic [PWM_BITS-1:0] scale(channel_t level, channel_t gain);
        product_t prod;
        prod = product_t'(level) * product_t'(gain);
        return prod[$bits(product_t)-1 -: PWM_BITS];
    endfunction

    always_ff @(posedge clk) begin
        if (!reset) begin
            lat_mode      <= MODE_OFF;
            lat_intensity <= '0;
        end else if (cmd.update) begin
            lat_mode      <= cmd.mode;
            lat_intensity <= cmd.intensity;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.update) begin
            lat_idx   <= cmd.color_idx[2:0];
            lat_color <= cmd.color;
        end
    end

    // unknown mode bytes land in the default branch and give black
    always_comb begin
        case (lat_mode)
            MODE_DIRECT:  src_color = lat_color;
            MODE_PALETTE: src_color = PALETTE[lat_idx];
            default:      src_color = '0;
        endcase
    end

    assign src_ch[0] = src_color.red;
    assign src_ch[1] = src_color.green;
    assign src_ch[2] = src_color.blue;
    assign src_ch[3] = src_color.white;

    always_comb begin
        for (int ch = 0; ch < NUM_CH; ch++) begin
            duty_next[ch] = scale(src_ch[ch], lat_intensity);
        end
    end

    assign cnt_wrap = (pwm_cnt == CNT_LAST);

    // new duties are loaded only at the wrap, so a period is never cut mid-way
    always_ff @(posedge clk) begin
        if (!reset) begin
            pwm_cnt    <= '0;
            duty       <= '{default: '0};
            off_active <= 1'b1;
        end else if (cnt_wrap) begin
            pwm_cnt    <= '0;
            duty       <= duty_next;
            off_active <= (lat_mode != MODE_DIRECT) && (lat_mode != MODE_PALETTE);
        end else begin
            pwm_cnt <= pwm_cnt + PWM_BITS'(1);
        end
    end

    always_comb begin
        for (int ch = 0; ch < NUM_CH; ch++) begin
            pwm_out[ch] = (pwm_cnt < duty[ch]);
        end
    end

    assign pwm_red   = pwm_out[0];
    assign pwm_green = pwm_out[1];
    assign pwm_blue  = pwm_out[2];
    assign pwm_white = pwm_out[3];

    // the duties in force came from an off mode, so every LED must be dark
    a_off_dark : assert property (
        @(posedge clk) disable iff (!reset) off_active |-> (pwm_out == '0)
    ) else $error("pwm output active while mode is off");

endmodule

// File: hdl/spi_byte_rx.sv
// SPI mode-0 slave receiver that synchronizes the pins and delivers whole bytes
`timescale 1ns/1ps

module spi_byte_rx (
    input  logic       clk,
    input  logic       reset,
    input  logic       sclk,
    input  logic       cs_n,
    input  logic       mosi,
    output logic [7:0] rx_byte,
    output logic       rx_valid,
    output logic       frame_abort
);

    // two synchronizer flops per pin, plus a history flop for edge detection
    logic       sclk_meta;
    logic       sclk_sync;
    logic       sclk_prev;
    logic       cs_meta;
    logic       cs_sync;
    logic       cs_prev;
    logic       mosi_meta;
    logic       mosi_sync;
    logic       sclk_rise;
    logic       cs_rise;
    logic [2:0] bit_cnt;
    logic [6:0] shift_reg;

    // chip select idles high so the synchronizer starts deasserted
    always_ff @(posedge clk) begin
        if (!reset) begin
            sclk_meta <= 1'b0;
            sclk_sync <= 1'b0;
            sclk_prev <= 1'b0;
            cs_meta   <= 1'b1;
            cs_sync   <= 1'b1;
            cs_prev   <= 1'b1;
        end else begin
            sclk_meta <= sclk;
            sclk_sync <= sclk_meta;
            sclk_prev <= sclk_sync;
            cs_meta   <= cs_n;
            cs_sync   <= cs_meta;
            cs_prev   <= cs_sync;
        end
    end

    always_ff @(posedge clk) begin
        mosi_meta <= mosi;
        mosi_sync <= mosi_meta;
    end

    assign sclk_rise = sclk_sync & ~sclk_prev;
    assign cs_rise   = cs_sync & ~cs_prev;

    always_ff @(posedge clk) begin
        if (!reset) begin
            bit_cnt     <= '0;
            rx_valid    <= 1'b0;
            frame_abort <= 1'b0;
        end else begin
            rx_valid    <= 1'b0;
            frame_abort <= cs_rise;
            if (cs_sync) begin
                bit_cnt <= '0;
            end else if (sclk_rise) begin
                // the counter wraps to zero after the eighth bit by itself
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7) begin
                    rx_valid <= 1'b1;
                end
            end
        end
    end

    // msb arrives first, so older bits move up
    always_ff @(posedge clk) begin
        if (sclk_rise && !cs_sync) begin
            shift_reg <= {shift_reg[5:0], mosi_sync};
            if (bit_cnt == 3'd7) begin
                rx_byte <= {shift_reg, mosi_sync};
            end
        end
    end

    // eight sclk edges separate two bytes, so a byte strobe can never repeat
    a_rx_valid_single : assert property (
        @(posedge clk) disable iff (!reset) rx_valid |=> !rx_valid
    ) else $error("rx_valid held for more than one cycle");

endmodule

// File: project.f
hdl/frame_pkg.sv
hdl/led_pkg.sv
hdl/led_cmd_if.sv
hdl/spi_byte_rx.sv
hdl/frame_dispatcher.sv
hdl/pwm_color_gen.sv
hdl/led_ctrl_top.sv
test/tb_led_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# build the LED controller testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_led_ctrl -o tb_led_ctrl

status=0
./obj_dir/tb_led_ctrl > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: test/tb_led_ctrl.sv
// testbench for the SPI LED controller that sends frames and measures the PWM duty of each channel
`timescale 1ns/1ps

module tb_led_ctrl;
    import frame_pkg::*;
    import led_pkg::*;

    localparam logic [7:0] SYNC_BYTE  = 8'h55;
    localparam int         PWM_BITS   = 8;
    localparam int         PWM_PERIOD = (1 << PWM_BITS) - 1;
    localparam int         NUM_MEAS   = 23;
    // two junk bytes, the sync byte and seven payload bytes at 64 clk cycles each
    localparam int         FRAME_CYCLES = 10 * 64 + 16;
    localparam int         WATCHDOG_CYCLES = NUM_MEAS * (FRAME_CYCLES + 3 * PWM_PERIOD) + 1000;

    logic       clk;
    logic       reset;
    logic       sclk;
    logic       cs_n;
    logic       mosi;
    logic       pwm_red;
    logic       pwm_green;
    logic       pwm_blue;
    logic       pwm_white;
    logic [3:0] pwm_bus;

    logic [31:0] lfsr_state = 32'h4bc6;
    int          exp_duty [4];
    int          error_count;
    int          check_count;
    string       ch_name [4] = '{"pwm_red", "pwm_green", "pwm_blue", "pwm_white"};
    event        start_meas;
    event        meas_done;

    led_ctrl_top #(
        .SYNC_BYTE (SYNC_BYTE),
        .PWM_BITS  (PWM_BITS)
    ) u_led_ctrl_top (
        .clk       (clk),
        .reset     (reset),
        .sclk      (sclk),
        .cs_n      (cs_n),
        .mosi      (mosi),
        .pwm_red   (pwm_red),
        .pwm_green (pwm_green),
        .pwm_blue  (pwm_blue),
        .pwm_white (pwm_white)
    );

    assign pwm_bus = {pwm_white, pwm_blue, pwm_green, pwm_red};

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // taps 32, 22, 2 and 1 give a maximal length sequence
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic random_byte(output logic [7:0] val);
        int i;
        val = '0;
        for (i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[6:0], lfsr_state[0]};
        end
    endtask

    task automatic random_color(output rgbw_t color);
        random_byte(color.red);
        random_byte(color.green);
        random_byte(color.blue);
        random_byte(color.white);
    endtask

    // duty is the upper PWM_BITS bits of the 16-bit product of level and intensity
    function automatic int expected_duty(input logic [7:0] mode, input logic [7:0] color_idx,
                                         input rgbw_t color, input int channel,
                                         input logic [7:0] intensity);
        rgbw_t       src;
        channel_t    level;
        logic [15:0] prod;
        case (mode)
            MODE_DIRECT:  src = color;
            MODE_PALETTE: src = PALETTE[color_idx[2:0]];
            default:      src = '0;
        endcase
        case (channel)
            0:       level = src.red;
            1:       level = src.green;
            2:       level = src.blue;
            default: level = src.white;
        endcase
        prod = {8'd0, level} * {8'd0, intensity};
        return int'(prod >> (16 - PWM_BITS));
    endfunction

    task automatic set_expected(input logic [7:0] mode, input logic [7:0] color_idx,
                                input rgbw_t color, input logic [7:0] intensity);
        int c;
        for (c = 0; c < 4; c++) begin
            exp_duty[c] = expected_duty(mode, color_idx, color, c, intensity);
        end
    endtask

    task automatic check_val(input string name, input int got, input int expected);
        check_count++;
        if (got != expected) begin
            error_count++;
            $display("error at %0t ns: %s got %0d expected %0d", $time, name, got, expected);
        end
    endtask

    // a mode 0 master changes mosi while sclk is low and the slave samples it on the rise
    task automatic send_byte(input logic [7:0] b);
        int i;
        for (i = 7; i >= 0; i--) begin
            sclk <= 1'b0;
            mosi <= b[i];
            repeat (4) @(posedge clk);
            sclk <= 1'b1;
            repeat (4) @(posedge clk);
        end
        sclk <= 1'b0;
    endtask

    // payload_bytes below seven cuts the frame short with a cs_n rise
    task automatic send_frame(input logic [7:0] intensity, input logic [7:0] color_idx,
                              input rgbw_t color, input logic [7:0] mode,
                              input int payload_bytes, input int junk_bytes);
        logic [7:0] payload [FRAME_FIELDS];
        int         i;
        payload[0] = intensity;
        payload[1] = color_idx;
        payload[2] = color.red;
        payload[3] = color.green;
        payload[4] = color.blue;
        payload[5] = color.white;
        payload[6] = mode;
        cs_n <= 1'b0;
        repeat (4) @(posedge clk);
        for (i = 0; i < junk_bytes; i++) begin
            send_byte(8'ha0 + 8'(i));
        end
        send_byte(SYNC_BYTE);
        for (i = 0; i < payload_bytes; i++) begin
            send_byte(payload[i]);
        end
        repeat (4) @(posedge clk);
        cs_n <= 1'b1;
        repeat (8) @(posedge clk);
    endtask

    task automatic run_measurement();
        -> start_meas;
        @(meas_done);
        @(posedge clk);
    endtask

    // waits for the new duties to settle, then counts high cycles over one PWM period
    initial begin : measure_duty
        int high_cnt [4];
        int c;
        forever begin
            @(start_meas);
            repeat (2 * PWM_PERIOD) @(posedge clk);
            for (c = 0; c < 4; c++) begin
                high_cnt[c] = 0;
            end
            repeat (PWM_PERIOD) begin
                @(negedge clk);
                for (c = 0; c < 4; c++) begin
                    if (pwm_bus[c]) begin
                        high_cnt[c]++;
                    end
                end
            end
            for (c = 0; c < 4; c++) begin
                check_val(ch_name[c], high_cnt[c], exp_duty[c]);
            end
            -> meas_done;
        end
    end

    initial begin : stimulus
        rgbw_t      color;
        logic [7:0] intensity;
        logic [7:0] idx;
        int         k;
        reset = 1'b0;
        sclk = 1'b0;
        cs_n = 1'b1;
        mosi = 1'b0;
        error_count = 0;
        check_count = 0;
        for (k = 0; k < 4; k++) begin
            exp_duty[k] = 0;
        end
        repeat (8) @(posedge clk);
        reset <= 1'b1;
        @(posedge clk);

        // outputs stay dark after reset
        run_measurement();

        // direct colors at full intensity
        for (k = 0; k < 4; k++) begin
            random_color(color);
            random_byte(idx);
            send_frame(8'hff, idx, color, MODE_DIRECT, FRAME_FIELDS, 0);
            set_expected(MODE_DIRECT, idx, color, 8'hff);
            run_measurement();
        end

        // the same color is scaled by intensity and the first intensity is zero
        for (k = 0; k < 4; k++) begin
            if (k == 0) begin
                intensity = 8'h00;
            end else begin
                random_byte(intensity);
            end
            send_frame(intensity, idx, color, MODE_DIRECT, FRAME_FIELDS, 0);
            set_expected(MODE_DIRECT, idx, color, intensity);
            run_measurement();
        end

        // the upper index bits and the color bytes must not matter for palette entries
        for (k = 0; k < NUM_COLORS; k++) begin
            random_color(color);
            random_byte(idx);
            idx[2:0] = 3'(k);
            send_frame(8'hff, idx, color, MODE_PALETTE, FRAME_FIELDS, 0);
            set_expected(MODE_PALETTE, idx, color, 8'hff);
            run_measurement();
        end

        // junk before the sync byte is skipped
        random_color(color);
        send_frame(8'd200, 8'd0, color, MODE_DIRECT, FRAME_FIELDS, 2);
        set_expected(MODE_DIRECT, 8'd0, color, 8'd200);
        run_measurement();

        // a cut frame keeps the previous duties
        random_color(color);
        send_frame(8'hff, 8'd3, color, MODE_PALETTE, 4, 0);
        run_measurement();

        send_frame(8'd128, 8'd5, color, MODE_PALETTE, FRAME_FIELDS, 0);
        set_expected(MODE_PALETTE, 8'd5, color, 8'd128);
        run_measurement();

        // off mode and an unknown mode byte both turn every channel off
        random_color(color);
        send_frame(8'hff, 8'd0, color, MODE_OFF, FRAME_FIELDS, 0);
        set_expected(MODE_OFF, 8'd0, color, 8'hff);
        run_measurement();

        // warm white lights all four channels before the unknown mode byte arrives
        send_frame(8'hff, 8'd7, color, MODE_PALETTE, FRAME_FIELDS, 0);
        set_expected(MODE_PALETTE, 8'd7, color, 8'hff);
        run_measurement();

        send_frame(8'hff, 8'd0, color, 8'h7e, FRAME_FIELDS, 0);
        set_expected(8'h7e, 8'd0, color, 8'hff);
        run_measurement();

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule
